// ==== logic/l2_pkg.sv ====
/*
 * Shared sizes, types and line helpers for the second-level memory model.
 * Modules refer to everything here by scoped name.
 */
`default_nettype none

package l2_pkg;

	localparam int L2_MEM_LINES = 4096;
	localparam int L2_INDEX_BITS = 12;
	localparam int L2_LINE_WORDS = 16;
	localparam int L2_LINE_BYTES = 64;
	localparam int L2_WORD_SEL_BITS = 4;
	localparam int L2_LINE_ADDR_BITS = 26;

	typedef logic [L2_LINE_ADDR_BITS-1:0] line_addr_t;
	typedef logic [L2_LINE_ADDR_BITS+L2_WORD_SEL_BITS-1:0] word_addr_t;
	typedef logic [L2_WORD_SEL_BITS-1:0] word_sel_t;

	// Word 0 and byte 0 sit at the top of the line
	typedef logic [L2_LINE_BYTES*8-1:0] line_t;
	typedef logic [L2_LINE_BYTES-1:0] mask_t;
	typedef logic [3:0] be_t;

	typedef struct packed {
		logic valid;
		word_addr_t addr;
		logic [31:0] data;
		be_t be;
	} store_req_t;

	typedef struct packed {
		logic valid;
		line_addr_t addr;
		line_t data;
		mask_t mask;
	} line_wr_t;

	typedef enum logic {
		FETCH_IDLE,
		FETCH_REFILL
	} fetch_state_t;

	function automatic logic [31:0] line_word(input line_t line, input word_sel_t sel);
		return line[L2_LINE_BYTES*8-1 - 32*sel -: 32];
	endfunction

	// Bytes enabled in mask come from upd, the rest from base
	function automatic line_t merge_line(input line_t base, input line_t upd,
		input mask_t mask);
		line_t res;
		res = base;
		for (int i = 0; i < L2_LINE_BYTES; i++)
		begin
			if (mask[L2_LINE_BYTES-1-i])
				res[L2_LINE_BYTES*8-1 - 8*i -: 8] = upd[L2_LINE_BYTES*8-1 - 8*i -: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// ==== logic/l2_line_store.sv ====
/*
 * Word-organized line memory. Two registered line read ports and one
 * byte-masked line write port, each acknowledged one cycle after its strobe.
 * Contents start at zero and line addresses wrap modulo the store size.
 */
`timescale 1ns/1ns
`default_nettype none

module l2_line_store (
	input wire clk,
	input wire rst_i,

	input wire dread_i,
	input wire l2_pkg::line_addr_t daddr_i,
	output logic dack_o,
	output l2_pkg::line_t dline_o,

	input wire l2_pkg::line_wr_t wr_i,
	output logic wack_o,

	input wire iread_i,
	input wire l2_pkg::line_addr_t iaddr_i,
	output logic iack_o,
	output l2_pkg::line_t iline_o
);

	logic [31:0] mem [l2_pkg::L2_MEM_LINES * l2_pkg::L2_LINE_WORDS];

	initial
	begin
		for (int i = 0; i < l2_pkg::L2_MEM_LINES * l2_pkg::L2_LINE_WORDS; i++)
			mem[i] = '0;
	end

	// Gather the 16 words of one line, word 0 on top
	function automatic l2_pkg::line_t read_line(input l2_pkg::line_addr_t addr);
		l2_pkg::line_t line;
		for (int w = 0; w < l2_pkg::L2_LINE_WORDS; w++)
		begin
			line[l2_pkg::L2_LINE_BYTES*8-1 - 32*w -: 32] =
				mem[{addr[l2_pkg::L2_INDEX_BITS-1:0], l2_pkg::word_sel_t'(w)}];
		end
		return line;
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			dack_o <= 1'b0;
			wack_o <= 1'b0;
			iack_o <= 1'b0;
		end
		else
		begin
			dack_o <= dread_i;
			wack_o <= wr_i.valid;
			iack_o <= iread_i;
		end
	end

	// Reads see memory as it was before any write on the same edge
	always_ff @(posedge clk)
	begin
		if (dread_i)
			dline_o <= read_line(daddr_i);
		if (iread_i)
			iline_o <= read_line(iaddr_i);
	end

	always @(posedge clk)
	begin : write_port
		l2_pkg::line_t merged;
		if (wr_i.valid)
		begin
			merged = l2_pkg::merge_line(read_line(wr_i.addr), wr_i.data, wr_i.mask);
			for (int w = 0; w < l2_pkg::L2_LINE_WORDS; w++)
			begin
				mem[{wr_i.addr[l2_pkg::L2_INDEX_BITS-1:0], l2_pkg::word_sel_t'(w)}] <=
					l2_pkg::line_word(merged, l2_pkg::word_sel_t'(w));
			end
		end
	end

	// The data port never issues a write without enabled bytes
	a_wr_mask_nonzero: assert property (@(posedge clk) disable iff (rst_i)
		wr_i.valid |-> wr_i.mask != '0)
	else
		$error("line write with empty byte mask");

endmodule

`default_nettype wire

// ==== logic/l2_data_port.sv ====
/*
 * Data side of the second-level memory. Gathers word stores into one pending
 * masked line, writes it out on a line change or flush, and overlays the
 * pending bytes on line loads of the same line.
 */
`timescale 1ns/1ns
`default_nettype none

module l2_data_port (
	input wire clk,
	input wire rst_i,

	input wire load_i,
	input wire l2_pkg::line_addr_t load_addr_i,
	output logic load_ack_o,
	output l2_pkg::line_t load_line_o,
	input wire l2_pkg::store_req_t store_i,
	input wire flush_i,

	output logic rd_o,
	output l2_pkg::line_addr_t rd_addr_o,
	input wire rd_ack_i,
	input wire l2_pkg::line_t rd_line_i,
	output l2_pkg::line_wr_t wr_o,
	input wire wack_i
);

	logic pend_valid;
	l2_pkg::line_addr_t pend_addr;
	l2_pkg::line_t pend_line;
	l2_pkg::mask_t pend_mask;
	logic flush_defer;

	logic nxt_valid;
	l2_pkg::line_addr_t nxt_addr;
	l2_pkg::line_t nxt_line;
	l2_pkg::mask_t nxt_mask;
	logic nxt_defer;

	l2_pkg::line_addr_t st_addr;
	l2_pkg::word_sel_t st_word;
	l2_pkg::line_t st_data;
	l2_pkg::mask_t st_mask;
	logic evict;
	logic flush_req;

	l2_pkg::line_t fwd_line;
	l2_pkg::mask_t fwd_mask;

	assign st_addr = store_i.addr[$bits(l2_pkg::word_addr_t)-1:l2_pkg::L2_WORD_SEL_BITS];
	assign st_word = store_i.addr[l2_pkg::L2_WORD_SEL_BITS-1:0];
	assign evict = store_i.valid && pend_valid && pend_addr != st_addr;
	assign flush_req = flush_i || flush_defer;

	always_comb
	begin
		// Store word placed at its slot in an otherwise empty line
		st_data = '0;
		st_mask = '0;
		st_data[l2_pkg::L2_LINE_BYTES*8-1 - 32*st_word -: 32] = store_i.data;
		st_mask[l2_pkg::L2_LINE_BYTES-1 - 4*st_word -: 4] = store_i.be;

		nxt_valid = pend_valid;
		nxt_addr = pend_addr;
		nxt_line = pend_line;
		nxt_mask = pend_mask;
		nxt_defer = 1'b0;
		wr_o = '{valid: 1'b0, addr: pend_addr, data: pend_line, mask: pend_mask};

		if (store_i.valid)
		begin
			if (evict)
			begin
				wr_o.valid = 1'b1;
				nxt_line = st_data;
				nxt_mask = st_mask;
			end
			else
			begin
				nxt_line = l2_pkg::merge_line(pend_line, st_data, st_mask);
				nxt_mask = pend_mask | st_mask;
			end
			nxt_valid = 1'b1;
			nxt_addr = st_addr;
		end

		// Write port is busy with the eviction, so the flush waits a cycle
		if (flush_req && nxt_valid)
		begin
			if (evict)
				nxt_defer = 1'b1;
			else
			begin
				wr_o = '{valid: 1'b1, addr: nxt_addr, data: nxt_line, mask: nxt_mask};
				nxt_valid = 1'b0;
				nxt_mask = '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			pend_valid <= 1'b0;
			pend_mask <= '0;
			flush_defer <= 1'b0;
			fwd_mask <= '0;
		end
		else
		begin
			pend_valid <= nxt_valid;
			pend_mask <= nxt_mask;
			flush_defer <= nxt_defer;
			if (load_i)
			begin
				if (wr_o.valid && wr_o.addr == load_addr_i)
					fwd_mask <= wr_o.mask;
				else if (nxt_valid && nxt_addr == load_addr_i)
					fwd_mask <= nxt_mask;
				else
					fwd_mask <= '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		pend_addr <= nxt_addr;
		pend_line <= nxt_line;
		// The memory read misses this edge's write, so forward it too
		if (load_i)
			fwd_line <= (wr_o.valid && wr_o.addr == load_addr_i) ? wr_o.data : nxt_line;
	end

	assign rd_o = load_i;
	assign rd_addr_o = load_addr_i;
	assign load_ack_o = rd_ack_i;
	assign load_line_o = l2_pkg::merge_line(rd_line_i, fwd_line, fwd_mask);

	a_wack_after_write: assert property (@(posedge clk) disable iff (rst_i)
		wack_i |-> $past(wr_o.valid))
	else
		$error("write acknowledge without a write");

	a_pend_mask: assert property (@(posedge clk) disable iff (rst_i)
		pend_valid |-> pend_mask != '0)
	else
		$error("pending line holds no enabled bytes");

endmodule

`default_nettype wire

// ==== logic/l2_fetch_buffer.sv ====
/*
 * Instruction side of the second-level memory. Holds the last fetched line
 * and serves 32-bit words, hits in one cycle and misses in two.
 */
`timescale 1ns/1ns
`default_nettype none

module l2_fetch_buffer (
	input wire clk,
	input wire rst_i,

	input wire fetch_i,
	input wire l2_pkg::word_addr_t fetch_addr_i,
	input wire invalidate_i,
	output logic fetch_ack_o,
	output logic [31:0] instr_o,

	output logic rd_o,
	output l2_pkg::line_addr_t rd_addr_o,
	input wire rd_ack_i,
	input wire l2_pkg::line_t rd_line_i
);

	l2_pkg::fetch_state_t state;
	logic buf_valid;
	l2_pkg::line_addr_t buf_addr;
	l2_pkg::line_t buf_line;
	l2_pkg::word_sel_t word_q;

	l2_pkg::line_addr_t fetch_line;
	l2_pkg::word_sel_t fetch_word;
	logic hit;

	assign fetch_line =
		fetch_addr_i[$bits(l2_pkg::word_addr_t)-1:l2_pkg::L2_WORD_SEL_BITS];
	assign fetch_word = fetch_addr_i[l2_pkg::L2_WORD_SEL_BITS-1:0];
	assign hit = buf_valid && buf_addr == fetch_line;

	assign rd_o = fetch_i && state == l2_pkg::FETCH_IDLE && !hit;
	assign rd_addr_o = fetch_line;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state <= l2_pkg::FETCH_IDLE;
			buf_valid <= 1'b0;
			fetch_ack_o <= 1'b0;
		end
		else
		begin
			fetch_ack_o <= 1'b0;
			case (state)
				l2_pkg::FETCH_IDLE:
				begin
					if (fetch_i && hit)
						fetch_ack_o <= 1'b1;
					else if (fetch_i)
					begin
						buf_valid <= 1'b0;
						state <= l2_pkg::FETCH_REFILL;
					end
				end
				l2_pkg::FETCH_REFILL:
				begin
					if (rd_ack_i)
					begin
						buf_valid <= 1'b1;
						fetch_ack_o <= 1'b1;
						state <= l2_pkg::FETCH_IDLE;
					end
				end
				default:
					state <= l2_pkg::FETCH_IDLE;
			endcase
			// Software invalidate wins over a refill landing on the same edge
			if (invalidate_i)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch_i)
			word_q <= fetch_word;
		if (rd_o)
			buf_addr <= fetch_line;
		if (fetch_i && hit)
			instr_o <= l2_pkg::line_word(buf_line, fetch_word);
		if (state == l2_pkg::FETCH_REFILL && rd_ack_i)
		begin
			buf_line <= rd_line_i;
			instr_o <= l2_pkg::line_word(rd_line_i, word_q);
		end
	end

	a_no_fetch_in_refill: assert property (@(posedge clk) disable iff (rst_i)
		fetch_i |-> state != l2_pkg::FETCH_REFILL)
	else
		$error("fetch issued before previous fetch acknowledged");

	// Line store answers every refill on the next cycle
	a_refill_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
		state == l2_pkg::FETCH_REFILL |-> rd_ack_i)
	else
		$error("refill line did not return in one cycle");

endmodule

`default_nettype wire

// ==== logic/l2_subsystem.sv ====
/*
 * Top level of the second-level memory model. Data port and fetch buffer
 * share one line store.
 */
`timescale 1ns/1ns
`default_nettype none

module l2_subsystem (
	input wire clk,
	input wire rst_i,

	input wire load_i,
	input wire l2_pkg::line_addr_t load_addr_i,
	output logic load_ack_o,
	output l2_pkg::line_t load_line_o,
	input wire l2_pkg::store_req_t store_i,
	input wire flush_i,

	input wire fetch_i,
	input wire l2_pkg::word_addr_t fetch_addr_i,
	input wire invalidate_i,
	output logic fetch_ack_o,
	output logic [31:0] instr_o
);

	logic d_rd;
	l2_pkg::line_addr_t d_rd_addr;
	logic d_rd_ack;
	l2_pkg::line_t d_rd_line;
	l2_pkg::line_wr_t d_wr;
	logic d_wack;

	logic i_rd;
	l2_pkg::line_addr_t i_rd_addr;
	logic i_rd_ack;
	l2_pkg::line_t i_rd_line;

	l2_data_port data_port_i (
		.clk(clk),
		.rst_i(rst_i),
		.load_i(load_i),
		.load_addr_i(load_addr_i),
		.load_ack_o(load_ack_o),
		.load_line_o(load_line_o),
		.store_i(store_i),
		.flush_i(flush_i),
		.rd_o(d_rd),
		.rd_addr_o(d_rd_addr),
		.rd_ack_i(d_rd_ack),
		.rd_line_i(d_rd_line),
		.wr_o(d_wr),
		.wack_i(d_wack)
	);

	l2_fetch_buffer fetch_buffer_i (
		.clk(clk),
		.rst_i(rst_i),
		.fetch_i(fetch_i),
		.fetch_addr_i(fetch_addr_i),
		.invalidate_i(invalidate_i),
		.fetch_ack_o(fetch_ack_o),
		.instr_o(instr_o),
		.rd_o(i_rd),
		.rd_addr_o(i_rd_addr),
		.rd_ack_i(i_rd_ack),
		.rd_line_i(i_rd_line)
	);

	l2_line_store line_store_i (
		.clk(clk),
		.rst_i(rst_i),
		.dread_i(d_rd),
		.daddr_i(d_rd_addr),
		.dack_o(d_rd_ack),
		.dline_o(d_rd_line),
		.wr_i(d_wr),
		.wack_o(d_wack),
		.iread_i(i_rd),
		.iaddr_i(i_rd_addr),
		.iack_o(i_rd_ack),
		.iline_o(i_rd_line)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
/*
 * Testbench clock and reset source. 100 ns clock period; reset is held
 * high over the first two rising edges and released after a short delay.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_i
);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		rst_i = 1'b1;
		repeat (2) @(posedge clk);
		#10 rst_i = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/tb_l2_subsystem.sv ====
/*
 * Directed testbench for the second-level memory model. Drives the data and
 * instruction ports and checks them against a byte-array model of 16 lines.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_l2_subsystem;

	localparam int TEST_CYCLES = 90;
	localparam int MARGIN_CYCLES = 50;
	localparam int WATCHDOG_NS = (TEST_CYCLES + MARGIN_CYCLES) * 100;

	logic clk;
	logic rst_i;
	logic load_i;
	l2_pkg::line_addr_t load_addr_i;
	logic load_ack_o;
	l2_pkg::line_t load_line_o;
	l2_pkg::store_req_t store_i;
	logic flush_i;
	logic fetch_i;
	l2_pkg::word_addr_t fetch_addr_i;
	logic invalidate_i;
	logic fetch_ack_o;
	logic [31:0] instr_o;

	// Reference bytes in line-major order with byte 0 of a line first
	logic [7:0] model [0:16*64-1];
	logic [31:0] lcg_state;

	tb_clock clock_i (
		.clk(clk),
		.rst_i(rst_i)
	);

	l2_subsystem dut_i (
		.clk(clk),
		.rst_i(rst_i),
		.load_i(load_i),
		.load_addr_i(load_addr_i),
		.load_ack_o(load_ack_o),
		.load_line_o(load_line_o),
		.store_i(store_i),
		.flush_i(flush_i),
		.fetch_i(fetch_i),
		.fetch_addr_i(fetch_addr_i),
		.invalidate_i(invalidate_i),
		.fetch_ack_o(fetch_ack_o),
		.instr_o(instr_o)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic l2_pkg::line_t model_line(input int line);
		l2_pkg::line_t res;
		for (int b = 0; b < 64; b++)
			res[511 - 8*b -: 8] = model[line*64 + b];
		return res;
	endfunction

	function automatic logic [31:0] model_word(input int line, input int word);
		int base;
		base = line*64 + word*4;
		return {model[base], model[base+1], model[base+2], model[base+3]};
	endfunction

	task automatic fail_run();
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_line(input l2_pkg::line_t got, input l2_pkg::line_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s\n  got      %h\n  expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_instr(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	// Inputs change 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic store_word(input int line, input int word, input logic [31:0] value,
		input l2_pkg::be_t be);
		store_i.valid = 1'b1;
		store_i.addr = {l2_pkg::line_addr_t'(line), l2_pkg::word_sel_t'(word)};
		store_i.data = value;
		store_i.be = be;
		for (int b = 0; b < 4; b++)
		begin
			if (be[3-b])
				model[line*64 + word*4 + b] = value[31 - 8*b -: 8];
		end
		next_cycle();
		store_i = '0;
	endtask

	task automatic random_store(input int line);
		logic [31:0] r;
		l2_pkg::be_t be;
		r = lcg_next();
		be = r[3:0];
		if (be == 4'b0000)
			be = 4'b1000;
		store_word(line, r[7:4], lcg_next(), be);
	endtask

	task automatic flush_pending();
		flush_i = 1'b1;
		next_cycle();
		flush_i = 1'b0;
	endtask

	task automatic load_and_check(input int line, input string what);
		load_i = 1'b1;
		load_addr_i = l2_pkg::line_addr_t'(line);
		next_cycle();
		load_i = 1'b0;
		if (load_ack_o !== 1'b1)
		begin
			$display("Load of line %0d was not acknowledged one cycle after its strobe (%0t)",
				line, $time);
			fail_run();
		end
		check_line(load_line_o, model_line(line), what);
	endtask

	task automatic fetch_and_check(input int line, input int word, input bit expect_hit,
		input string what);
		fetch_i = 1'b1;
		fetch_addr_i = {l2_pkg::line_addr_t'(line), l2_pkg::word_sel_t'(word)};
		next_cycle();
		fetch_i = 1'b0;
		if (!expect_hit)
		begin
			if (fetch_ack_o !== 1'b0)
			begin
				$display("Fetch of line %0d acknowledged after one cycle but should miss (%0t)",
					line, $time);
				fail_run();
			end
			next_cycle();
		end
		if (fetch_ack_o !== 1'b1)
		begin
			$display("Fetch of line %0d word %0d was not acknowledged on its cycle (%0t)",
				line, word, $time);
			fail_run();
		end
		check_instr(instr_o, model_word(line, word), what);
	endtask

	task automatic after_reset();
		repeat (3)
		begin
			next_cycle();
			if (load_ack_o !== 1'b0 || fetch_ack_o !== 1'b0)
			begin
				$display("An acknowledge was high after reset with no strobe (%0t)", $time);
				fail_run();
			end
		end
		load_and_check(9, "unwritten line after reset");
	endtask

	task automatic partial_stores();
		// Full-word fill gives the kept bytes nonzero values
		for (int w = 0; w < 16; w++)
			store_word(3, w, lcg_next(), 4'b1111);
		// Store to another line evicts the fill and restarts the pending line
		store_word(4, 0, lcg_next(), 4'b1111);
		for (int i = 0; i < 10; i++)
			random_store(3);
		flush_pending();
		load_and_check(3, "line after partial stores and flush");
	endtask

	task automatic forwarding();
		for (int i = 0; i < 3; i++)
			random_store(3);
		load_and_check(3, "pending bytes forwarded");
		load_and_check(9, "other line while a line is pending");
		for (int i = 0; i < 3; i++)
			random_store(3);
		load_and_check(3, "forwarding after more stores");
		flush_pending();
		load_and_check(3, "line after flush");
	endtask

	task automatic eviction();
		for (int i = 0; i < 8; i++)
			random_store(10 + (i % 2));
		load_and_check(10, "evicted line while the other is pending");
		flush_pending();
		load_and_check(10, "first alternating line");
		load_and_check(11, "second alternating line");
	endtask

	task automatic fetch_refill();
		fetch_and_check(3, 2, 1'b0, "instruction on miss");
		fetch_and_check(3, 5, 1'b1, "instruction on hit");
		store_word(3, 5, lcg_next(), 4'b1111);
		flush_pending();
		invalidate_i = 1'b1;
		next_cycle();
		invalidate_i = 1'b0;
		fetch_and_check(3, 5, 1'b0, "instruction after invalidate");
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		fail_run();
	end

	initial
	begin
		load_i = 1'b0;
		load_addr_i = '0;
		store_i = '0;
		flush_i = 1'b0;
		fetch_i = 1'b0;
		fetch_addr_i = '0;
		invalidate_i = 1'b0;
		lcg_state = 32'd49;
		for (int i = 0; i < 16*64; i++)
			model[i] = 8'h00;

		wait (rst_i === 1'b0);
		next_cycle();

		after_reset();
		partial_stores();
		forwarding();
		eviction();
		fetch_refill();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== l2_subsystem.f ====
logic/l2_pkg.sv
logic/l2_line_store.sv
logic/l2_data_port.sv
logic/l2_fetch_buffer.sv
logic/l2_subsystem.sv
tests/tb_clock.sv
tests/tb_l2_subsystem.sv
